// ==== Makefile ====
# build and run the memory unit testbench with Verilator

.PHONY: sim clean

sim:
	verilator --binary --timing --timescale 1ns/1ps -Wno-fatal --top-module tb_mem_unit -f src.f
	./obj_dir/Vtb_mem_unit > sim.log 2>&1 || true
	cat sim.log
	grep -q "Simulation completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== mem_pkg.sv ====
// shared widths and encodings for the memory access unit
// work RAM is 8 KB, higher address bits alias onto it

package mem_pkg;

    typedef logic [23:0] addr_t;    // byte address
    typedef logic [15:0] word_t;    // bus word, also the status word
    typedef logic [31:0] long_t;    // operand and fetch data
    typedef logic [ 2:0] len_t;     // one-hot write length
    typedef logic [ 1:0] dsel_t;    // write data source
    typedef logic [ 1:0] be_t;      // bit 0 = low byte (even address)

    // write sequencer beats
    typedef enum logic [1:0] {
        WR_IDLE,
        WR_SECOND,
        WR_THIRD
    } wr_state_t;

    // word address width of the work RAM
    localparam int RAM_AW = 12;

    // bit positions inside len_t
    localparam int LEN_BYTE = 0;
    localparam int LEN_WORD = 1;
    localparam int LEN_LONG = 2;

    // write data sources, 0 and 3 both pick the operand
    localparam dsel_t DSEL_PC = 2'd1;
    localparam dsel_t DSEL_SR = 2'd2;

endpackage

// ==== mem_unit_top.sv ====
// memory access unit: pointer registers, RAM controller and work RAM
// zero wait state bus, users wait on ram_rdy

module mem_unit_top (
    input  logic           clk,
    input  logic           rst,
    input  logic           cen,
    input  mem_pkg::long_t ld_data,
    input  logic           pc_ld,
    input  logic           xsp_ld,
    input  logic           sr_ld,
    input  logic           fetch_take,
    input  logic [1:0]     fetch_cnt,
    input  logic           ldram_en,
    input  mem_pkg::addr_t idx_addr,
    input  logic           sel_xsp,
    input  mem_pkg::dsel_t data_sel,
    input  mem_pkg::long_t operand,
    input  mem_pkg::len_t  len,
    input  logic           idx_wr,
    output mem_pkg::long_t dout,
    output logic           ram_rdy,
    output mem_pkg::addr_t pc
);

    mem_pkg::addr_t xsp;
    mem_pkg::word_t sr;
    mem_pkg::addr_t ram_addr;
    mem_pkg::word_t ram_din;
    mem_pkg::word_t ram_dout;
    mem_pkg::be_t   ram_we;

    ptr_regs u_regs (
        .clk        (clk),
        .rst        (rst),
        .cen        (cen),
        .ld_data    (ld_data),
        .pc_ld      (pc_ld),
        .xsp_ld     (xsp_ld),
        .sr_ld      (sr_ld),
        .fetch_take (fetch_take),
        .fetch_cnt  (fetch_cnt),
        .ram_rdy    (ram_rdy),
        .ldram_en   (ldram_en),
        .pc         (pc),
        .xsp        (xsp),
        .sr         (sr)
    );

    ram_ctl u_ctl (
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .ldram_en (ldram_en),
        .idx_addr (idx_addr),
        .xsp      (xsp),
        .sr       (sr),
        .pc       (pc),
        .sel_xsp  (sel_xsp),
        .data_sel (data_sel),
        .operand  (operand),
        .idx_wr   (idx_wr),
        .len      (len),
        .ram_dout (ram_dout),
        .ram_addr (ram_addr),
        .ram_din  (ram_din),
        .ram_we   (ram_we),
        .dout     (dout),
        .ram_rdy  (ram_rdy)
    );

    work_ram u_ram (
        .clk      (clk),
        .ram_addr (ram_addr),
        .ram_din  (ram_din),
        .ram_we   (ram_we),
        .ram_dout (ram_dout)
    );

endmodule

// ==== ptr_regs.sv ====
// pc, stack pointer and status word
// a fetch advance counts only while ram_rdy is high and the pc is the read address

module ptr_regs (
    input  logic           clk,
    input  logic           rst,
    input  logic           cen,
    input  mem_pkg::long_t ld_data,
    input  logic           pc_ld,
    input  logic           xsp_ld,
    input  logic           sr_ld,
    input  logic           fetch_take,
    input  logic [1:0]     fetch_cnt,   // 0..3 means 1..4 bytes
    input  logic           ram_rdy,
    input  logic           ldram_en,
    output mem_pkg::addr_t pc,
    output mem_pkg::addr_t xsp,
    output mem_pkg::word_t sr
);

    logic           fetch_ok;
    mem_pkg::addr_t pc_step;

    // fetch consumed from the prefetch buffer
    assign fetch_ok = fetch_take && ram_rdy && !ldram_en;
    assign pc_step  = mem_pkg::addr_t'(fetch_cnt) + 24'd1;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc <= '0;
        end else if (cen) begin
            if (pc_ld) begin
                pc <= ld_data[23:0];    // load wins over advance
            end else if (fetch_ok) begin
                pc <= pc + pc_step;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            xsp <= '0;
        end else if (cen && xsp_ld) begin
            xsp <= ld_data[23:0];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sr <= '0;
        end else if (cen && sr_ld) begin
            sr <= ld_data[15:0];
        end
    end

endmodule

// ==== ram_ctl.sv ====
// prefetch read buffer and split write sequencer for a zero wait state RAM
// write data, address and length must stay put until ram_rdy comes back

module ram_ctl (
    input  logic              clk,
    input  logic              rst,
    input  logic              cen,
    input  logic              ldram_en,
    input  mem_pkg::addr_t    idx_addr,
    input  mem_pkg::addr_t    xsp,
    input  mem_pkg::word_t    sr,
    input  mem_pkg::addr_t    pc,
    input  logic              sel_xsp,
    input  mem_pkg::dsel_t    data_sel,
    input  mem_pkg::long_t    operand,
    input  logic              idx_wr,
    input  mem_pkg::len_t     len,
    input  mem_pkg::word_t    ram_dout,
    output mem_pkg::addr_t    ram_addr,
    output mem_pkg::word_t    ram_din,
    output mem_pkg::be_t      ram_we,
    output mem_pkg::long_t    dout,
    output logic              ram_rdy
);

    mem_pkg::addr_t    req_addr, wr_addr, buf_addr;
    mem_pkg::long_t    wr_data, buf_q;
    logic [3:0]        buf_ok, fill_mask, fill_en;
    logic              wr_busy, wr_go, rd_ok, miss, odd;
    logic              step1, step2, step3;
    logic [7:0]        byte_a, byte_b;
    mem_pkg::wr_state_t wr_state, beat_next;
    mem_pkg::word_t    beat_din;
    mem_pkg::be_t      beat_we;

    assign req_addr = ldram_en ? idx_addr : pc;
    assign wr_addr  = sel_xsp ? xsp : idx_addr;
    assign ram_rdy  = (&buf_ok) && (buf_addr == req_addr) && !wr_busy;
    assign dout     = buf_q;

    always_comb begin
        case (data_sel)
            mem_pkg::DSEL_PC: wr_data = {8'd0, pc};
            mem_pkg::DSEL_SR: wr_data = {16'd0, sr};
            default:          wr_data = operand;
        endcase
    end

    assign wr_go = idx_wr || (wr_state != mem_pkg::WR_IDLE);
    assign rd_ok = !wr_go && !wr_busy;     // bus free for the read side

    // next write beat
    always_comb begin
        beat_din  = wr_data[15:0];
        beat_we   = 2'b11;
        beat_next = mem_pkg::WR_IDLE;
        case (wr_state)
            mem_pkg::WR_IDLE: begin
                if (len[mem_pkg::LEN_BYTE] || wr_addr[0]) begin
                    beat_din = {2{wr_data[7:0]}};   // byte in both lanes
                end
                if (len[mem_pkg::LEN_BYTE]) begin
                    beat_we = {wr_addr[0], ~wr_addr[0]};
                end else if (wr_addr[0]) begin
                    beat_we = 2'b10;
                end
                if (len[mem_pkg::LEN_LONG] || (len[mem_pkg::LEN_WORD] && wr_addr[0])) begin
                    beat_next = mem_pkg::WR_SECOND;
                end
            end
            mem_pkg::WR_SECOND: begin
                if (!wr_addr[0]) begin
                    beat_din = wr_data[31:16];      // even long, upper half
                end else if (len[mem_pkg::LEN_WORD]) begin
                    beat_din = {2{wr_data[15:8]}};
                    beat_we  = 2'b01;
                end else begin
                    beat_din  = wr_data[23:8];      // odd long, middle bytes
                    beat_next = mem_pkg::WR_THIRD;
                end
            end
            mem_pkg::WR_THIRD: begin
                beat_din = {2{wr_data[31:24]}};
                beat_we  = 2'b01;
            end
            default: begin
                beat_next = mem_pkg::WR_IDLE;
            end
        endcase
    end

    // read side decisions
    assign odd  = buf_addr[0];
    assign miss = ((req_addr != buf_addr) || (buf_ok != 4'hf)) && (fill_mask == 4'd0);
    assign step1 = (req_addr == buf_addr + 24'd1) && (buf_ok[3:1] == 3'b111);
    assign step2 = (req_addr == buf_addr + 24'd2) && (buf_ok[3:2] == 2'b11);
    assign step3 = (req_addr == buf_addr + 24'd3) && buf_ok[3];

    // bytes in address order, one word can serve at most two of them
    assign fill_en[0] = fill_mask[0];
    assign fill_en[1] = fill_mask[1] && (!odd || !fill_mask[0]);
    assign fill_en[2] = fill_mask[2] && !fill_mask[0] && (!fill_mask[1] || odd);
    assign fill_en[3] = fill_mask[3] && !fill_mask[1] && (!odd || !fill_mask[2]);

    assign byte_a = odd ? ram_dout[15:8] : ram_dout[7:0];  // buffer bytes 0 and 2
    assign byte_b = odd ? ram_dout[7:0]  : ram_dout[15:8]; // buffer bytes 1 and 3

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_state  <= mem_pkg::WR_IDLE;
            wr_busy   <= 1'b0;
            ram_we    <= '0;
            ram_addr  <= '0;
            buf_addr  <= '0;
            buf_ok    <= '0;
            fill_mask <= '0;
        end else if (cen) begin
            wr_busy <= 1'b0;
            ram_we  <= '0;
            if (wr_go) begin
                ram_addr <= (wr_state == mem_pkg::WR_IDLE) ? wr_addr : ram_addr + 24'd2;
                ram_we   <= beat_we;
                wr_state <= beat_next;
                wr_busy  <= 1'b1;
                if (wr_state == mem_pkg::WR_IDLE) begin
                    buf_ok    <= '0;    // drop stale read data
                    fill_mask <= '0;
                end
            end else if (!wr_busy) begin
                if (fill_mask != 4'd0) begin
                    ram_addr  <= ram_addr + 24'd2;
                    buf_ok    <= buf_ok | fill_en;
                    fill_mask <= fill_mask & ~fill_en;
                end else if (miss) begin
                    buf_addr <= req_addr;
                    if (step1) begin
                        ram_addr  <= req_addr + 24'd3;
                        fill_mask <= 4'b1000;
                        buf_ok    <= 4'b0111;
                    end else if (step2) begin
                        ram_addr  <= req_addr + 24'd2;
                        fill_mask <= 4'b1100;
                        buf_ok    <= 4'b0011;
                    end else if (step3) begin
                        ram_addr  <= req_addr + {23'd0, req_addr[0]};
                        fill_mask <= 4'b1110;
                        buf_ok    <= 4'b0001;
                    end else begin
                        ram_addr  <= req_addr;  // full reload
                        fill_mask <= 4'b1111;
                        buf_ok    <= 4'b0000;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cen && wr_go) begin
            ram_din <= beat_din;
        end
    end

    // buffer bytes, shifted down on a forward step
    always_ff @(posedge clk) begin
        if (cen && rd_ok) begin
            if (fill_mask != 4'd0) begin
                if (fill_en[0]) buf_q[7:0]   <= byte_a;
                if (fill_en[1]) buf_q[15:8]  <= byte_b;
                if (fill_en[2]) buf_q[23:16] <= byte_a;
                if (fill_en[3]) buf_q[31:24] <= byte_b;
            end else if (miss) begin
                if (step1) begin
                    buf_q <= {8'd0, buf_q[31:8]};
                end else if (step2) begin
                    buf_q <= {16'd0, buf_q[31:16]};
                end else if (step3) begin
                    buf_q <= {24'd0, buf_q[31:24]};
                end
            end
        end
    end

endmodule

// ==== src.f ====
mem_pkg.sv
ptr_regs.sv
ram_ctl.sv
work_ram.sv
mem_unit_top.sv
tb_clkgen.sv
tb_mem_unit.sv

// ==== tb_clkgen.sv ====
// clock and reset for the memory unit testbench
// 100 ns period, reset high for the first 10 rising edges

module tb_clkgen (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (10) @(posedge clk);
        #5;
        rst = 1'b0;     // released 5 ns after the edge like the stimulus
    end

endmodule

// ==== tb_mem_unit.sv ====
// testbench for mem_unit_top with a byte mirror of the work RAM as reference
// dout is compared on every falling edge while ram_rdy is high
// addresses above 8 KB alias in the mirror the same way as in the RAM

module tb_mem_unit;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int MAX_CYCLES = 4000;   // about three times what the sequences below need
    localparam int MIN_CHECKS = 100;

    logic           clk;
    logic           rst;
    logic           cen;
    mem_pkg::long_t ld_data;
    logic           pc_ld;
    logic           xsp_ld;
    logic           sr_ld;
    logic           fetch_take;
    logic [1:0]     fetch_cnt;
    logic           ldram_en;
    mem_pkg::addr_t idx_addr;
    logic           sel_xsp;
    mem_pkg::dsel_t data_sel;
    mem_pkg::long_t operand;
    mem_pkg::len_t  len;
    logic           idx_wr;
    mem_pkg::long_t dout;
    logic           ram_rdy;
    mem_pkg::addr_t pc;

    logic [7:0]     mirror [8192];     // byte image of the work RAM
    mem_pkg::addr_t exp_addr;          // address the DUT should be reading
    mem_pkg::addr_t exp_pc;
    mem_pkg::word_t exp_sr;
    logic           mon_on;
    logic           jitter;            // random single cycle cen drops
    integer         seed = 39;
    int             cycles = 0;
    int             n_checks = 0;

    tb_clkgen u_clk (
        .clk (clk),
        .rst (rst)
    );

    mem_unit_top u_dut (
        .clk        (clk),
        .rst        (rst),
        .cen        (cen),
        .ld_data    (ld_data),
        .pc_ld      (pc_ld),
        .xsp_ld     (xsp_ld),
        .sr_ld      (sr_ld),
        .fetch_take (fetch_take),
        .fetch_cnt  (fetch_cnt),
        .ldram_en   (ldram_en),
        .idx_addr   (idx_addr),
        .sel_xsp    (sel_xsp),
        .data_sel   (data_sel),
        .operand    (operand),
        .len        (len),
        .idx_wr     (idx_wr),
        .dout       (dout),
        .ram_rdy    (ram_rdy),
        .pc         (pc)
    );

    // four little-endian bytes starting at a
    function automatic mem_pkg::long_t ref_long(input mem_pkg::addr_t a);
        mem_pkg::long_t r;
        mem_pkg::addr_t b;
        for (int i = 0; i < 4; i++) begin
            b = a + mem_pkg::addr_t'(i);
            r[8*i +: 8] = mirror[b[12:0]];
        end
        return r;
    endfunction

    task automatic mirror_write(input mem_pkg::addr_t a, input mem_pkg::len_t ln,
                                input mem_pkg::long_t d);
        int             n;
        mem_pkg::addr_t b;
        n = ln[2] ? 4 : (ln[1] ? 2 : 1);   // long, word, byte
        for (int i = 0; i < n; i++) begin
            b = a + mem_pkg::addr_t'(i);
            mirror[b[12:0]] = d[8*i +: 8];
        end
    endtask

    task automatic check_long(input mem_pkg::long_t got, input mem_pkg::long_t exp,
                              input string what);
        if (got !== exp) begin
            $display("[FAIL] %0d ns: %s is %h, expected %h", $time, what, got, exp);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    task automatic check_addr(input mem_pkg::addr_t got, input mem_pkg::addr_t exp,
                              input string what);
        if (got !== exp) begin
            $display("[FAIL] %0d ns: %s is %h, expected %h", $time, what, got, exp);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("[FAIL] %0d ns: %s is %b, expected %b", $time, what, got, exp);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    // waits at falling edges and drops cen for single cycles when jitter is on
    task automatic wait_ready();
        @(negedge clk);
        while (!ram_rdy) begin
            @(posedge clk);
            #5;
            if (jitter && cen && ($unsigned($random(seed)) % 4 == 0)) begin
                cen = 1'b0;
            end else begin
                cen = 1'b1;
            end
            @(negedge clk);
        end
    endtask

    task automatic read_at(input mem_pkg::addr_t a);
        @(posedge clk);
        #5;
        cen      = 1'b1;
        ldram_en = 1'b1;
        idx_addr = a;
        exp_addr = a;
        wait_ready();
    endtask

    // which selects 0 pc, 1 xsp or 2 sr
    task automatic load_reg(input logic [1:0] which, input mem_pkg::long_t v);
        @(posedge clk);
        #5;
        cen     = 1'b1;
        ld_data = v;
        pc_ld   = (which == 2'd0);
        xsp_ld  = (which == 2'd1);
        sr_ld   = (which == 2'd2);
        @(posedge clk);
        #5;
        pc_ld  = 1'b0;
        xsp_ld = 1'b0;
        sr_ld  = 1'b0;
        if (which == 2'd0) begin
            exp_pc = v[23:0];
            if (!ldram_en) exp_addr = exp_pc;
        end else if (which == 2'd2) begin
            exp_sr = v[15:0];
        end
    endtask

    // with idx_addr the read side stays on a and reads the new data straight back
    task automatic write_mem(input mem_pkg::addr_t a, input logic use_xsp,
                             input mem_pkg::dsel_t ds, input mem_pkg::len_t ln,
                             input mem_pkg::long_t d);
        mem_pkg::long_t wd;
        if (use_xsp) begin
            load_reg(2'd1, {8'd0, a});
            read_at(a + 24'h40);    // idx_addr away from the target
        end else begin
            read_at(a);
        end
        @(posedge clk);
        #5;
        cen      = 1'b1;
        sel_xsp  = use_xsp;
        data_sel = ds;
        len      = ln;
        operand  = d;
        idx_wr   = 1'b1;
        @(posedge clk);
        #5;
        idx_wr = 1'b0;
        case (ds)
            2'd1:    wd = {8'd0, exp_pc};
            2'd2:    wd = {16'd0, exp_sr};
            default: wd = d;
        endcase
        mirror_write(a, ln, wd);    // ram_rdy is already low here
        wait_ready();
    endtask

    // compare whenever the DUT claims valid read data
    always @(negedge clk) begin
        if (mon_on && ram_rdy) begin
            check_long(dout, ref_long(exp_addr), $sformatf("dout at %h", exp_addr));
            n_checks++;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Simulation failed");
            $fatal(1);
        end
    end

    initial begin
        mem_pkg::addr_t a;
        mem_pkg::len_t  ln;
        int             cnt;
        int             op;
        cen        = 1'b1;
        ld_data    = '0;
        pc_ld      = 1'b0;
        xsp_ld     = 1'b0;
        sr_ld      = 1'b0;
        fetch_take = 1'b0;
        fetch_cnt  = 2'd0;
        ldram_en   = 1'b0;
        idx_addr   = '0;
        sel_xsp    = 1'b0;
        data_sel   = 2'd0;
        operand    = '0;
        len        = 3'b001;
        idx_wr     = 1'b0;
        exp_addr   = '0;
        exp_pc     = '0;
        exp_sr     = '0;
        mon_on     = 1'b0;
        jitter     = 1'b0;
        for (int i = 0; i < 8192; i++) begin
            mirror[i] = 8'd0;
        end

        // reset state and then a cold fetch at 0
        @(negedge rst);
        @(negedge clk);
        check_bit(ram_rdy, 1'b0, "ram_rdy after reset");
        check_addr(pc, 24'd0, "pc after reset");
        mon_on = 1'b1;
        wait_ready();

        // byte, word and long writes at even and odd addresses through idx_addr and xsp
        for (int s = 0; s < 2; s++) begin
            for (int l = 0; l < 3; l++) begin
                for (int p = 0; p < 2; p++) begin
                    a = 24'h100 + mem_pkg::addr_t'(16 * (s * 6 + l * 2 + p) + p);
                    write_mem(a, s[0], 2'd0, mem_pkg::len_t'(1 << l), $random(seed));
                    read_at(a - 24'd1);     // neighbours on both sides
                    read_at(a + 24'd1);
                end
            end
        end

        // sr and pc as write data
        load_reg(2'd2, $random(seed));
        write_mem(24'h400, 1'b0, 2'd2, 3'b100, 32'hffff_ffff);
        check_long(dout, {16'd0, exp_sr}, "stored sr");
        load_reg(2'd0, 32'h0012_3457);
        write_mem(24'h409, 1'b0, 2'd1, 3'b100, 32'hffff_ffff);
        check_long(dout, {8'd0, exp_pc}, "stored pc");

        // sequential fetch through a patterned region
        for (int i = 0; i < 12; i++) begin
            a = 24'h300 + mem_pkg::addr_t'(4 * i);
            write_mem(a, 1'b0, 2'd0, 3'b100, {a[7:0] ^ 8'h5a, a});
        end
        load_reg(2'd0, 32'h0000_0301);
        @(posedge clk);
        #5;
        ldram_en = 1'b0;
        exp_addr = exp_pc;
        wait_ready();
        check_addr(pc, exp_pc, "pc after load");
        repeat (16) begin
            cnt = $unsigned($random(seed)) % 4;
            @(posedge clk);
            #5;
            fetch_take = 1'b1;
            fetch_cnt  = cnt[1:0];
            @(posedge clk);
            #5;
            fetch_take = 1'b0;
            exp_pc     = exp_pc + mem_pkg::addr_t'(cnt + 1);
            exp_addr   = exp_pc;
            wait_ready();
            check_addr(pc, exp_pc, "pc after fetch");
        end

        // random reads and writes with cen dropping now and then
        jitter = 1'b1;
        repeat (30) begin
            op = $unsigned($random(seed)) % 4;
            a  = mem_pkg::addr_t'($unsigned($random(seed)) % 8192);
            case (op)
                0: read_at(a);
                1: read_at(exp_addr + mem_pkg::addr_t'(1 + $unsigned($random(seed)) % 3));
                default: begin
                    ln = mem_pkg::len_t'(1 << ($unsigned($random(seed)) % 3));
                    write_mem(a, 1'b0, 2'd0, ln, $random(seed));
                    read_at(a - 24'd1);
                end
            endcase
        end
        jitter = 1'b0;

        if (n_checks >= MIN_CHECKS) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            $display("only %0d ready cycles were compared", n_checks);
            $display("Simulation failed");
            $fatal(1);
        end
    end

endmodule

// ==== work_ram.sv ====
// 16-bit work RAM, byte writes at the edge and asynchronous read
// only address bits RAM_AW..1 are decoded, no reset of contents

module work_ram (
    input  logic           clk,
    input  mem_pkg::addr_t ram_addr,
    input  mem_pkg::word_t ram_din,
    input  mem_pkg::be_t   ram_we,
    output mem_pkg::word_t ram_dout
);

    localparam int DEPTH = 2 ** mem_pkg::RAM_AW;

    mem_pkg::word_t            mem [DEPTH];
    logic [mem_pkg::RAM_AW-1:0] widx;

    assign widx     = ram_addr[mem_pkg::RAM_AW:1];    // byte address to word
    assign ram_dout = mem[widx];

    // blank memory for simulation
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (ram_we[0]) begin
            mem[widx][7:0] <= ram_din[7:0];     // even byte
        end
        if (ram_we[1]) begin
            mem[widx][15:8] <= ram_din[15:8];   // odd byte
        end
    end

endmodule
